/* fu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_alu
	import fu_stage_pkg::*;
(
	input  wire           clock,
	input  wire           reset,
	input  wire           start,
	input  wire alu_op_t  op,
	input  wire data_t    a,
	input  wire data_t    b,
	input  wire pr_idx_t  pr_idx,
	input  wire rob_idx_t rob_idx,
	input  wire           hold,
	output logic          done,
	output data_t         result,
	output pr_idx_t       done_pr_idx,
	output rob_idx_t      done_rob_idx
);

	data_t alu_out;

	always_comb begin
		case (op)
			ALU_ADD: alu_out = a + b;
			ALU_SUB: alu_out = a - b;
			ALU_AND: alu_out = a & b;
			ALU_OR:  alu_out = a | b;
			ALU_XOR: alu_out = a ^ b;
			ALU_SLL: alu_out = a << b[4:0];  // low 5 bits only
			ALU_SRL: alu_out = a >> b[4:0];
			ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
			default: alu_out = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// output register, frozen while refused
	always_ff @(posedge clock) begin
		if (reset)
			done <= 1'b0;
		else if (!hold)
			done <= start;
	end

	always_ff @(posedge clock) begin
		if (start && !hold) begin
			result       <= alu_out;
			done_pr_idx  <= pr_idx;
			done_rob_idx <= rob_idx;
		end
	end

	// a refused result must not be overwritten by a new issue
	a_start_not_held: assert property (@(posedge clock) disable iff (reset)
		!(start && hold));

endmodule

`default_nettype wire

/* fu_complete_arb.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_complete_arb
	import fu_stage_pkg::*;
(
	input  wire                               mult_done,
	input  wire data_t                        mult_result,
	input  wire pr_idx_t                      mult_pr_idx,
	input  wire rob_idx_t                     mult_rob_idx,
	input  wire                               alu0_done,
	input  wire data_t                        alu0_result,
	input  wire pr_idx_t                      alu0_pr_idx,
	input  wire rob_idx_t                     alu0_rob_idx,
	input  wire                               alu1_done,
	input  wire data_t                        alu1_result,
	input  wire pr_idx_t                      alu1_pr_idx,
	input  wire rob_idx_t                     alu1_rob_idx,
	output logic                              hold_mult,
	output logic                              hold_alu0,
	output logic                              hold_alu1,
	output logic     [COMPLETE_WAYS-1:0]      grant_valid,
	output data_t    [COMPLETE_WAYS-1:0]      grant_result,
	output pr_idx_t  [COMPLETE_WAYS-1:0]      grant_pr_idx,
	output rob_idx_t [COMPLETE_WAYS-1:0]      grant_rob_idx
);

	logic [1:0] cnt_mult, cnt_alu0, cnt_alu1;  // running done count, priority order

	always_comb begin
		cnt_mult = {1'b0, mult_done};
		cnt_alu0 = cnt_mult + {1'b0, alu0_done};
		cnt_alu1 = cnt_alu0 + {1'b0, alu1_done};
	end

	// done but past the slot limit -> keep result and stall
	assign hold_mult = mult_done && (cnt_mult > 2'(COMPLETE_WAYS));
	assign hold_alu0 = alu0_done && (cnt_alu0 > 2'(COMPLETE_WAYS));
	assign hold_alu1 = alu1_done && (cnt_alu1 > 2'(COMPLETE_WAYS));

	//////////////////////////////////////////////////
	// entry k takes the unit whose count reaches k+1
	always_comb begin
		grant_valid   = '0;
		grant_result  = '0;
		grant_pr_idx  = '0;
		grant_rob_idx = '0;
		for (int k = 0; k < COMPLETE_WAYS; k++) begin
			if (mult_done && (cnt_mult == 2'(k + 1))) begin
				grant_valid[k]   = 1'b1;
				grant_result[k]  = mult_result;
				grant_pr_idx[k]  = mult_pr_idx;
				grant_rob_idx[k] = mult_rob_idx;
			end else if (alu0_done && (cnt_alu0 == 2'(k + 1))) begin
				grant_valid[k]   = 1'b1;
				grant_result[k]  = alu0_result;
				grant_pr_idx[k]  = alu0_pr_idx;
				grant_rob_idx[k] = alu0_rob_idx;
			end else if (alu1_done && (cnt_alu1 == 2'(k + 1))) begin
				grant_valid[k]   = 1'b1;
				grant_result[k]  = alu1_result;
				grant_pr_idx[k]  = alu1_pr_idx;
				grant_rob_idx[k] = alu1_rob_idx;
			end
		end
	end

endmodule

`default_nettype wire

/* fu_issue_route.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_issue_route
	import fu_stage_pkg::*;
(
	input  wire                            clock,
	input  wire                            reset,
	input  wire  [ISSUE_WAYS-1:0]          issue_valid,
	input  wire  fu_sel_t  [ISSUE_WAYS-1:0] issue_fu_sel,
	input  wire  alu_op_t  [ISSUE_WAYS-1:0] issue_op,
	input  wire  data_t    [ISSUE_WAYS-1:0] issue_a,
	input  wire  data_t    [ISSUE_WAYS-1:0] issue_b,
	input  wire  pr_idx_t  [ISSUE_WAYS-1:0] issue_pr_idx,
	input  wire  rob_idx_t [ISSUE_WAYS-1:0] issue_rob_idx,
	input  wire                            hold_alu0,
	input  wire                            hold_alu1,
	input  wire                            hold_mult,
	output logic                           alu0_start,
	output alu_op_t                        alu0_op,
	output data_t                          alu0_a,
	output data_t                          alu0_b,
	output pr_idx_t                        alu0_pr_idx,
	output rob_idx_t                       alu0_rob_idx,
	output logic                           alu1_start,
	output alu_op_t                        alu1_op,
	output data_t                          alu1_a,
	output data_t                          alu1_b,
	output pr_idx_t                        alu1_pr_idx,
	output rob_idx_t                       alu1_rob_idx,
	output logic                           mult_start,
	output data_t                          mult_a,
	output data_t                          mult_b,
	output pr_idx_t                        mult_pr_idx,
	output rob_idx_t                       mult_rob_idx
);

	logic [ISSUE_WAYS-1:0] pick_alu0, pick_alu1, pick_mult;  // lane i wants unit

	always_comb begin
		for (int i = 0; i < ISSUE_WAYS; i++) begin
			pick_alu0[i] = issue_valid[i] && (issue_fu_sel[i] == FU_ALU0);
			pick_alu1[i] = issue_valid[i] && (issue_fu_sel[i] == FU_ALU1);
			pick_mult[i] = issue_valid[i] && (issue_fu_sel[i] == FU_MULT);
		end
	end

	//////////////////////////////////////////////////
	// lane to unit steering, idle units see zeros
	always_comb begin
		alu0_start   = 1'b0;
		alu0_op      = '0;
		alu0_a       = '0;
		alu0_b       = '0;
		alu0_pr_idx  = '0;
		alu0_rob_idx = '0;
		alu1_start   = 1'b0;
		alu1_op      = '0;
		alu1_a       = '0;
		alu1_b       = '0;
		alu1_pr_idx  = '0;
		alu1_rob_idx = '0;
		mult_start   = 1'b0;
		mult_a       = '0;
		mult_b       = '0;
		mult_pr_idx  = '0;
		mult_rob_idx = '0;
		for (int i = 0; i < ISSUE_WAYS; i++) begin
			if (pick_alu0[i]) begin
				alu0_start   = 1'b1;
				alu0_op      = issue_op[i];
				alu0_a       = issue_a[i];
				alu0_b       = issue_b[i];
				alu0_pr_idx  = issue_pr_idx[i];
				alu0_rob_idx = issue_rob_idx[i];
			end
			if (pick_alu1[i]) begin
				alu1_start   = 1'b1;
				alu1_op      = issue_op[i];
				alu1_a       = issue_a[i];
				alu1_b       = issue_b[i];
				alu1_pr_idx  = issue_pr_idx[i];
				alu1_rob_idx = issue_rob_idx[i];
			end
			if (pick_mult[i]) begin  // op ignored, low product only
				mult_start   = 1'b1;
				mult_a       = issue_a[i];
				mult_b       = issue_b[i];
				mult_pr_idx  = issue_pr_idx[i];
				mult_rob_idx = issue_rob_idx[i];
			end
		end
	end

	// issuer contract against the arbiter's holds
	a_unit_once: assert property (@(posedge clock) disable iff (reset)
		$onehot0(pick_alu0) && $onehot0(pick_alu1) && $onehot0(pick_mult));

	a_no_held_pick: assert property (@(posedge clock) disable iff (reset)
		!((hold_alu0 && |pick_alu0) || (hold_alu1 && |pick_alu1) || (hold_mult && |pick_mult)));

endmodule

`default_nettype wire

/* fu_mult.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_mult
	import fu_stage_pkg::*;
#(
	parameter int MULT_STAGES = 3
) (
	input  wire           clock,
	input  wire           reset,
	input  wire           start,
	input  wire data_t    a,
	input  wire data_t    b,
	input  wire pr_idx_t  pr_idx,
	input  wire rob_idx_t rob_idx,
	input  wire           hold,
	output logic          done,
	output data_t         result,
	output pr_idx_t       done_pr_idx,
	output rob_idx_t      done_rob_idx
);

	// each stage adds one slice of b times a
	localparam int    CHUNK      = (XLEN + MULT_STAGES - 1) / MULT_STAGES;
	localparam data_t CHUNK_MASK = data_t'((64'd1 << CHUNK) - 64'd1);

	logic [MULT_STAGES-1:0] stg_valid, in_valid;
	data_t    stg_acc [MULT_STAGES];
	pr_idx_t  stg_pr  [MULT_STAGES];
	rob_idx_t stg_rob [MULT_STAGES];
	data_t    stg_a   [MULT_STAGES-1];  // last stage needs no operands
	data_t    stg_b   [MULT_STAGES-1];
	data_t    in_a    [MULT_STAGES];
	data_t    in_b    [MULT_STAGES];
	data_t    in_acc  [MULT_STAGES];
	pr_idx_t  in_pr   [MULT_STAGES];
	rob_idx_t in_rob  [MULT_STAGES];
	data_t    partial [MULT_STAGES];

	//////////////////////////////////////////////////
	// per stage inputs and partial sums
	always_comb begin
		data_t chunk;
		in_valid  = {stg_valid[MULT_STAGES-2:0], start};
		in_a[0]   = a;
		in_b[0]   = b;
		in_acc[0] = '0;
		in_pr[0]  = pr_idx;
		in_rob[0] = rob_idx;
		for (int s = 1; s < MULT_STAGES; s++) begin
			in_a[s]   = stg_a[s-1];
			in_b[s]   = stg_b[s-1];
			in_acc[s] = stg_acc[s-1];
			in_pr[s]  = stg_pr[s-1];
			in_rob[s] = stg_rob[s-1];
		end
		for (int s = 0; s < MULT_STAGES; s++) begin
			chunk      = (in_b[s] >> (s * CHUNK)) & CHUNK_MASK;
			partial[s] = in_acc[s] + ((in_a[s] * chunk) << (s * CHUNK));  // mod 2^XLEN
		end
	end

	//////////////////////////////////////////////////
	// pipe registers, whole pipe freezes on hold
	always_ff @(posedge clock) begin
		if (reset)
			stg_valid <= '0;
		else if (!hold)
			stg_valid <= in_valid;
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			for (int s = 0; s < MULT_STAGES; s++) begin
				stg_acc[s] <= partial[s];
				stg_pr[s]  <= in_pr[s];
				stg_rob[s] <= in_rob[s];
			end
			for (int s = 0; s < MULT_STAGES - 1; s++) begin
				stg_a[s] <= in_a[s];
				stg_b[s] <= in_b[s];
			end
		end
	end

	assign done         = stg_valid[MULT_STAGES-1];
	assign result       = stg_acc[MULT_STAGES-1];
	assign done_pr_idx  = stg_pr[MULT_STAGES-1];
	assign done_rob_idx = stg_rob[MULT_STAGES-1];

	// a frozen pipe cannot take a new product
	a_start_not_held: assert property (@(posedge clock) disable iff (reset)
		!(start && hold));

endmodule

`default_nettype wire

/* fu_rob_order.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_rob_order
	import fu_stage_pkg::*;
(
	input  wire      [COMPLETE_WAYS-1:0] grant_valid,
	input  wire data_t    [COMPLETE_WAYS-1:0] grant_result,
	input  wire pr_idx_t  [COMPLETE_WAYS-1:0] grant_pr_idx,
	input  wire rob_idx_t [COMPLETE_WAYS-1:0] grant_rob_idx,
	output logic     [COMPLETE_WAYS-1:0] complete_valid,
	output data_t    [COMPLETE_WAYS-1:0] complete_result,
	output pr_idx_t  [COMPLETE_WAYS-1:0] complete_pr_idx,
	output rob_idx_t [COMPLETE_WAYS-1:0] complete_rob_idx
);

	logic swap;

	// oldest into slot 0, a lone entry always lands in slot 0
	// rob index compared unsigned, no wrap handling
	assign swap = grant_valid[1] &&
		(!grant_valid[0] || (grant_rob_idx[1] < grant_rob_idx[0]));

	always_comb begin
		if (swap) begin
			complete_valid   = {grant_valid[0], grant_valid[1]};
			complete_result  = {grant_result[0], grant_result[1]};
			complete_pr_idx  = {grant_pr_idx[0], grant_pr_idx[1]};
			complete_rob_idx = {grant_rob_idx[0], grant_rob_idx[1]};
		end else begin
			complete_valid   = grant_valid;
			complete_result  = grant_result;
			complete_pr_idx  = grant_pr_idx;
			complete_rob_idx = grant_rob_idx;
		end
	end

endmodule

`default_nettype wire

/* fu_stage.f */
fu_stage_pkg.sv
fu_issue_route.sv
fu_alu.sv
fu_mult.sv
fu_complete_arb.sv
fu_rob_order.sv
fu_stage.sv
tb_fu_stage.sv

/* fu_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_stage
	import fu_stage_pkg::*;
#(
	parameter int MULT_STAGES = 3  // 2 to 4
) (
	input  wire                              clock,
	input  wire                              reset,
	input  wire      [ISSUE_WAYS-1:0]        issue_valid,
	input  wire fu_sel_t  [ISSUE_WAYS-1:0]   issue_fu_sel,
	input  wire alu_op_t  [ISSUE_WAYS-1:0]   issue_op,
	input  wire data_t    [ISSUE_WAYS-1:0]   issue_a,
	input  wire data_t    [ISSUE_WAYS-1:0]   issue_b,
	input  wire pr_idx_t  [ISSUE_WAYS-1:0]   issue_pr_idx,
	input  wire rob_idx_t [ISSUE_WAYS-1:0]   issue_rob_idx,
	output logic                             stall_alu0,
	output logic                             stall_alu1,
	output logic                             stall_mult,
	output logic     [COMPLETE_WAYS-1:0]     complete_valid,
	output data_t    [COMPLETE_WAYS-1:0]     complete_result,
	output pr_idx_t  [COMPLETE_WAYS-1:0]     complete_pr_idx,
	output rob_idx_t [COMPLETE_WAYS-1:0]     complete_rob_idx
);

	//////////////////////////////////////////////////
	// route -> units
	logic     alu0_start, alu1_start, mult_start;
	alu_op_t  alu0_op, alu1_op;
	data_t    alu0_a, alu0_b, alu1_a, alu1_b, mult_a, mult_b;
	pr_idx_t  alu0_pr_idx, alu1_pr_idx, mult_pr_idx;
	rob_idx_t alu0_rob_idx, alu1_rob_idx, mult_rob_idx;

	// units -> arbiter, all registered
	logic     alu0_done, alu1_done, mult_done;
	data_t    alu0_result, alu1_result, mult_result;
	pr_idx_t  alu0_done_pr, alu1_done_pr, mult_done_pr;
	rob_idx_t alu0_done_rob, alu1_done_rob, mult_done_rob;

	// arbiter -> orderer
	logic     [COMPLETE_WAYS-1:0] grant_valid;
	data_t    [COMPLETE_WAYS-1:0] grant_result;
	pr_idx_t  [COMPLETE_WAYS-1:0] grant_pr_idx;
	rob_idx_t [COMPLETE_WAYS-1:0] grant_rob_idx;

	fu_issue_route route_i (
		.clock, .reset,
		.issue_valid, .issue_fu_sel, .issue_op, .issue_a, .issue_b,
		.issue_pr_idx, .issue_rob_idx,
		.hold_alu0(stall_alu0), .hold_alu1(stall_alu1), .hold_mult(stall_mult),
		.alu0_start, .alu0_op, .alu0_a, .alu0_b, .alu0_pr_idx, .alu0_rob_idx,
		.alu1_start, .alu1_op, .alu1_a, .alu1_b, .alu1_pr_idx, .alu1_rob_idx,
		.mult_start, .mult_a, .mult_b, .mult_pr_idx, .mult_rob_idx
	);

	fu_alu alu0_i (
		.clock, .reset,
		.start(alu0_start), .op(alu0_op), .a(alu0_a), .b(alu0_b),
		.pr_idx(alu0_pr_idx), .rob_idx(alu0_rob_idx), .hold(stall_alu0),
		.done(alu0_done), .result(alu0_result),
		.done_pr_idx(alu0_done_pr), .done_rob_idx(alu0_done_rob)
	);

	fu_alu alu1_i (
		.clock, .reset,
		.start(alu1_start), .op(alu1_op), .a(alu1_a), .b(alu1_b),
		.pr_idx(alu1_pr_idx), .rob_idx(alu1_rob_idx), .hold(stall_alu1),
		.done(alu1_done), .result(alu1_result),
		.done_pr_idx(alu1_done_pr), .done_rob_idx(alu1_done_rob)
	);

	fu_mult #(.MULT_STAGES(MULT_STAGES)) mult_i (
		.clock, .reset,
		.start(mult_start), .a(mult_a), .b(mult_b),
		.pr_idx(mult_pr_idx), .rob_idx(mult_rob_idx), .hold(stall_mult),
		.done(mult_done), .result(mult_result),
		.done_pr_idx(mult_done_pr), .done_rob_idx(mult_done_rob)
	);

	fu_complete_arb arb_i (
		.mult_done, .mult_result, .mult_pr_idx(mult_done_pr), .mult_rob_idx(mult_done_rob),
		.alu0_done, .alu0_result, .alu0_pr_idx(alu0_done_pr), .alu0_rob_idx(alu0_done_rob),
		.alu1_done, .alu1_result, .alu1_pr_idx(alu1_done_pr), .alu1_rob_idx(alu1_done_rob),
		.hold_mult(stall_mult), .hold_alu0(stall_alu0), .hold_alu1(stall_alu1),
		.grant_valid, .grant_result, .grant_pr_idx, .grant_rob_idx
	);

	fu_rob_order order_i (
		.grant_valid, .grant_result, .grant_pr_idx, .grant_rob_idx,
		.complete_valid, .complete_result, .complete_pr_idx, .complete_rob_idx
	);

endmodule

`default_nettype wire

/* fu_stage_input.txt */
# one issue group per line, three lanes of seven hex fields each
# sel op a b pr rob expected   (sel 0 none 1 alu0 2 alu1 3 mult, op 0..7 add..slt)
# alu operations, two lanes per group
1 0 5 7 01 00 c  2 1 10 3 02 01 d  0 0 0 0 0 0 0
1 0 ffffffff 1 03 02 0  2 1 0 1 04 03 ffffffff  0 0 0 0 0 0 0
1 2 f0f0f0f0 ff00ff00 05 04 f000f000  2 3 f0f0f0f0 0f0f0000 06 05 fffff0f0  0 0 0 0 0 0 0
1 4 12345678 ffffffff 07 06 edcba987  2 4 aaaa5555 5555aaaa 08 07 ffffffff  0 0 0 0 0 0 0
1 5 1 1f 09 08 80000000  2 5 3 24 0a 09 30  0 0 0 0 0 0 0
1 6 80000000 1f 0b 0a 1  2 6 f0000000 21 0c 0b 78000000  0 0 0 0 0 0 0
1 7 ffffffff 1 0d 0c 1  2 7 1 ffffffff 0e 0d 0  0 0 0 0 0 0 0
1 7 7fffffff 80000000 0f 0e 0  2 7 80000000 7fffffff 10 0f 1  0 0 0 0 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  2 0 100 23 11 10 123
2 1 3 5 12 11 fffffffe  0 0 0 0 0 0 0  1 2 12345678 ffff 13 12 5678
# back to back multiplies
3 0 7 6 14 13 2a  0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 0 10000 10000 15 14 0  0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 0 ffffffff ffffffff 16 15 1  0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 0 12345 10 17 16 123450  0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 0 abcd 1000 18 17 abcd000  0 0 0 0 0 0 0  0 0 0 0 0 0 0
# multiplier and both alus finishing together
3 0 80000001 3 19 18 80000003  0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 0 11111111 f 1a 19 ffffffff  0 0 0 0 0 0 0  0 0 0 0 0 0 0
1 0 1 2 1b 1a 3  2 1 64 1 1c 1b 63  0 0 0 0 0 0 0
1 3 100 1 1d 1c 101  3 0 2 2 1e 1d 4  0 0 0 0 0 0 0
2 2 ff f 1f 1e f  1 0 20 22 20 1f 42  0 0 0 0 0 0 0
3 0 3 3 21 00 9  0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 0 6 7 22 01 2a  1 1 50 8 23 02 48  2 4 f 3 24 03 c
1 2 ffff0000 12345678 25 04 12340000  2 3 0 5 26 05 5  0 0 0 0 0 0 0
1 0 7 8 27 06 f  2 5 1 4 28 07 10  0 0 0 0 0 0 0
# mixed traffic
3 0 12345678 2 29 08 2468acf0  0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 0 100 100 2a 09 10000  0 0 0 0 0 0 0  0 0 0 0 0 0 0
1 6 ffffffff 4 2b 0a fffffff  2 7 5 5 2c 0b 0  0 0 0 0 0 0 0
2 1 1000 1 2d 0c fff  3 0 0 12345 2e 0d 0  0 0 0 0 0 0 0
1 4 f0f ff 2f 0e ff0  0 0 0 0 0 0 0  0 0 0 0 0 0 0
2 0 7fffffff 1 30 0f 80000000  1 5 ffffffff 10 31 10 ffff0000  0 0 0 0 0 0 0
3 0 7 7 32 11 31  0 0 0 0 0 0 0  0 0 0 0 0 0 0
3 0 fffffffe 2 33 12 fffffffc  0 0 0 0 0 0 0  0 0 0 0 0 0 0
1 7 80000000 0 34 13 1  2 6 12345678 8 35 14 123456  0 0 0 0 0 0 0
0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 0 0 0 0 0
0 0 0 0 0 0 0  2 3 1 2 36 15 3  0 0 0 0 0 0 0

/* fu_stage_pkg.sv */
`default_nettype none

package fu_stage_pkg;

	//////////////////////////////////////////////////
	// widths
	localparam int XLEN          = 32;
	localparam int ROB_IDX_W     = 5;
	localparam int PR_IDX_W      = 6;
	localparam int ISSUE_WAYS    = 3;  // issue lanes per cycle
	localparam int COMPLETE_WAYS = 2;  // completion slots per cycle

	typedef logic [XLEN-1:0]      data_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [PR_IDX_W-1:0]  pr_idx_t;
	typedef logic [2:0]           alu_op_t;
	typedef logic [1:0]           fu_sel_t;

	//////////////////////////////////////////////////
	// alu opcodes
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR  = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_SLL = 3'd5;
	localparam alu_op_t ALU_SRL = 3'd6;
	localparam alu_op_t ALU_SLT = 3'd7;  // signed compare

	// unit select carried with each lane
	localparam fu_sel_t FU_NONE = 2'd0;
	localparam fu_sel_t FU_ALU0 = 2'd1;
	localparam fu_sel_t FU_ALU1 = 2'd2;
	localparam fu_sel_t FU_MULT = 2'd3;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fu_stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_fu_stage \
	-f fu_stage.f \
	-o sim_fu_stage

./obj_dir/sim_fu_stage 2>&1 | tee sim.log

if grep -qx "TEST PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb_fu_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fu_stage
	import fu_stage_pkg::*;
();

	localparam int MULT_STAGES = 3;
	localparam int MAX_GROUPS  = 64;
	localparam int FIELDS      = 7;  // sel op a b pr rob exp
	localparam int ROB_SIZE    = 2 ** ROB_IDX_W;

	logic                            clock = 1'b0;
	logic                            reset;
	logic     [ISSUE_WAYS-1:0]       issue_valid;
	fu_sel_t  [ISSUE_WAYS-1:0]       issue_fu_sel;
	alu_op_t  [ISSUE_WAYS-1:0]       issue_op;
	data_t    [ISSUE_WAYS-1:0]       issue_a;
	data_t    [ISSUE_WAYS-1:0]       issue_b;
	pr_idx_t  [ISSUE_WAYS-1:0]       issue_pr_idx;
	rob_idx_t [ISSUE_WAYS-1:0]       issue_rob_idx;
	logic                            stall_alu0, stall_alu1, stall_mult;
	logic     [COMPLETE_WAYS-1:0]    complete_valid;
	data_t    [COMPLETE_WAYS-1:0]    complete_result;
	pr_idx_t  [COMPLETE_WAYS-1:0]    complete_pr_idx;
	rob_idx_t [COMPLETE_WAYS-1:0]    complete_rob_idx;

	// issue groups as read from the input file
	int       n_groups;
	fu_sel_t  g_sel [MAX_GROUPS][ISSUE_WAYS];
	alu_op_t  g_op  [MAX_GROUPS][ISSUE_WAYS];
	data_t    g_a   [MAX_GROUPS][ISSUE_WAYS];
	data_t    g_b   [MAX_GROUPS][ISSUE_WAYS];
	pr_idx_t  g_pr  [MAX_GROUPS][ISSUE_WAYS];
	rob_idx_t g_rob [MAX_GROUPS][ISSUE_WAYS];
	data_t    g_exp [MAX_GROUPS][ISSUE_WAYS];

	//////////////////////////////////////////////////
	// scoreboard with one entry per rob index
	logic     pend_valid  [ROB_SIZE];
	data_t    pend_exp    [ROB_SIZE];
	pr_idx_t  pend_pr     [ROB_SIZE];
	fu_sel_t  pend_unit   [ROB_SIZE];
	int       pend_cycle  [ROB_SIZE];
	int       pend_stalls [ROB_SIZE];  // stall count seen at issue
	rob_idx_t mult_order  [$];

	int pending_count, mult_issued, mult_retired;
	int stall_cycles, alu1_stall_cycles;
	int cycle_count = 0;
	int cycle_limit = 1000;

	always #4 clock = ~clock;

	fu_stage #(.MULT_STAGES(MULT_STAGES)) fu_stage_i (
		.clock, .reset,
		.issue_valid, .issue_fu_sel, .issue_op, .issue_a, .issue_b,
		.issue_pr_idx, .issue_rob_idx,
		.stall_alu0, .stall_alu1, .stall_mult,
		.complete_valid, .complete_result, .complete_pr_idx, .complete_rob_idx
	);

	task automatic stop_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("ERROR at %0d ns: %s, got %h expected %h", $time, what, got, expected);
			stop_run();
		end
	endtask

	task automatic read_input();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [ISSUE_WAYS*FIELDS];
		fd = $fopen("fu_stage_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the input file fu_stage_input.txt");
			stop_run();
		end
		n_groups = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;  // blank or comment
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6],
				f[7], f[8], f[9], f[10], f[11], f[12], f[13],
				f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
			if (n != ISSUE_WAYS * FIELDS || n_groups == MAX_GROUPS) begin
				$display("bad or surplus line in the input file: %s", line);
				stop_run();
			end
			for (int l = 0; l < ISSUE_WAYS; l++) begin
				g_sel[n_groups][l] = fu_sel_t'(f[l*FIELDS]);
				g_op[n_groups][l]  = alu_op_t'(f[l*FIELDS+1]);
				g_a[n_groups][l]   = f[l*FIELDS+2];
				g_b[n_groups][l]   = f[l*FIELDS+3];
				g_pr[n_groups][l]  = pr_idx_t'(f[l*FIELDS+4]);
				g_rob[n_groups][l] = rob_idx_t'(f[l*FIELDS+5]);
				g_exp[n_groups][l] = f[l*FIELDS+6];
			end
			n_groups++;
		end
		$fclose(fd);
	endtask

	// a group waits while any unit it needs is stalled
	function automatic logic group_blocked(input int g);
		logic blocked;
		blocked = 1'b0;
		for (int l = 0; l < ISSUE_WAYS; l++) begin
			if (g_sel[g][l] == FU_ALU0 && stall_alu0)
				blocked = 1'b1;
			if (g_sel[g][l] == FU_ALU1 && stall_alu1)
				blocked = 1'b1;
			if (g_sel[g][l] == FU_MULT && stall_mult)
				blocked = 1'b1;
		end
		return blocked;
	endfunction

	task automatic issue_group(input int g);
		rob_idx_t rob;
		for (int l = 0; l < ISSUE_WAYS; l++) begin
			issue_valid[l]   = (g_sel[g][l] != FU_NONE);
			issue_fu_sel[l]  = g_sel[g][l];
			issue_op[l]      = g_op[g][l];
			issue_a[l]       = g_a[g][l];
			issue_b[l]       = g_b[g][l];
			issue_pr_idx[l]  = g_pr[g][l];
			issue_rob_idx[l] = g_rob[g][l];
			if (g_sel[g][l] != FU_NONE) begin
				rob = g_rob[g][l];
				compare_value(32'(pend_valid[rob]), 32'd0, "rob index reused while pending");
				pend_valid[rob]  = 1'b1;
				pend_exp[rob]    = g_exp[g][l];
				pend_pr[rob]     = g_pr[g][l];
				pend_unit[rob]   = g_sel[g][l];
				pend_cycle[rob]  = cycle_count;
				pend_stalls[rob] = stall_cycles;
				pending_count++;
				if (g_sel[g][l] == FU_MULT) begin
					mult_order.push_back(rob);
					mult_issued++;
				end
			end
		end
	endtask

	task automatic retire_slot(input int k);
		rob_idx_t    rob;
		int          latency;
		logic [31:0] nominal;
		rob = complete_rob_idx[k];
		compare_value(32'(pend_valid[rob]), 32'd1, "completion of a rob index not pending");
		compare_value(complete_result[k], pend_exp[rob], "completion result");
		compare_value(32'(complete_pr_idx[k]), 32'(pend_pr[rob]), "completion pr index");
		if (stall_alu1)
			compare_value(32'(pend_unit[rob] == FU_ALU1), 32'd0,
				"alu1 result completed while alu1 stalls");
		if (pend_unit[rob] == FU_MULT) begin
			compare_value(32'(rob), 32'(mult_order[0]), "multiplier completion order");
			void'(mult_order.pop_front());
			mult_retired++;
		end
		// fixed latency only if no unit stalled meanwhile
		if (pend_stalls[rob] == stall_cycles) begin
			latency = cycle_count - pend_cycle[rob];
			nominal = (pend_unit[rob] == FU_MULT) ? 32'(MULT_STAGES) : 32'd1;
			compare_value(32'(latency), nominal, "latency without back-pressure");
		end
		pend_valid[rob] = 1'b0;
		pending_count--;
	endtask

	//////////////////////////////////////////////////
	// completion monitor on the falling edge where outputs have settled
	always @(negedge clock) begin
		if (!reset) begin
			if (complete_valid[1])
				compare_value(32'(complete_valid[0]), 32'd1, "slot 1 valid without slot 0");
			if (&complete_valid)
				compare_value(32'(complete_rob_idx[0] < complete_rob_idx[1]), 32'd1,
					"slot 0 holds the older rob index");
			if (stall_alu0 || stall_alu1)
				compare_value(32'(complete_valid), 32'd3, "both slots used while a unit waits");
			compare_value(32'(stall_alu0), 32'd0, "alu0 stall under second priority");
			compare_value(32'(stall_mult), 32'd0, "multiplier stall under top priority");
			for (int k = 0; k < COMPLETE_WAYS; k++) begin
				if (complete_valid[k])
					retire_slot(k);
			end
			if (stall_alu1)
				alu1_stall_cycles++;
			if (stall_alu0 || stall_alu1 || stall_mult)
				stall_cycles++;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run passed %0d cycles with %0d results pending",
				cycle_limit, pending_count);
			stop_run();
		end
	end

	initial begin
		reset         = 1'b1;
		issue_valid   = '0;
		issue_fu_sel  = '0;
		issue_op      = '0;
		issue_a       = '0;
		issue_b       = '0;
		issue_pr_idx  = '0;
		issue_rob_idx = '0;
		pending_count = 0;
		mult_issued   = 0;
		mult_retired  = 0;
		stall_cycles  = 0;
		alu1_stall_cycles = 0;
		for (int r = 0; r < ROB_SIZE; r++)
			pend_valid[r] = 1'b0;
		read_input();
		cycle_limit = 20 * n_groups + 50;

		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		compare_value(32'(complete_valid), 32'd0, "complete_valid after reset");
		compare_value(32'({stall_alu0, stall_alu1, stall_mult}), 32'd0, "stalls after reset");

		for (int g = 0; g < n_groups; g++) begin
			while (group_blocked(g)) begin
				@(posedge clock);
				#1;
			end
			issue_group(g);
			@(posedge clock);
			#1;
			issue_valid = '0;
		end

		while (pending_count != 0) begin
			@(posedge clock);
			#1;
		end
		repeat (MULT_STAGES + 2) @(posedge clock);  // catch late duplicates

		compare_value(mult_retired, mult_issued, "completed multiplies against issued");
		compare_value(32'(alu1_stall_cycles != 0), 32'd1, "alu1 back-pressure seen");
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
